// ==== design/cpu_bus_if.sv ====
/*
 * CPU bus bundle
 * request signals of the 68000 core plus the derived read, write and active terms
 */
`timescale 1ns/100ps

interface cpu_bus_if;

	logic [ql_map_pkg::CPU_ADDR_W-1:0] addr;
	ql_bus_pkg::bus_state_t            state;
	logic                              write_n;
	logic                              uds;
	logic                              lds;
	logic [ql_bus_pkg::DATA_W-1:0]     wdata;

	// derived terms, shared by all consumers
	logic rd;
	logic wr;
	logic act;

	// code fetch counts as a read
	assign rd  = (state == ql_bus_pkg::BUS_FETCH) || (state == ql_bus_pkg::BUS_READ);
	assign wr  = (state == ql_bus_pkg::BUS_WRITE) && !write_n;
	assign act = rd || wr;

	modport source (output addr, state, write_n, uds, lds, wdata);
	modport consumer (input addr, state, write_n, uds, lds, wdata, rd, wr, act);

endinterface

// ==== design/ql_addr_decode.sv ====
/*
 * QL address decoder
 * maps an active CPU access to a region and raises the I/O chip selects
 */
`timescale 1ns/100ps

module ql_addr_decode (
	cpu_bus_if.consumer          bus,
	input  logic                 video_cycle,
	input  logic                 ram_640k,
	output ql_map_pkg::region_t  region,
	output logic                 zx8301_cs,
	output logic                 zx8302_sel,
	output logic [1:0]           zx8302_addr,
	output logic                 qimi_sel,
	output logic [1:0]           qimi_addr
);

	logic is_io;
	logic cpu_slot;

	// true when a lies in [base, base + size)
	// a below base wraps around and fails the size compare
	function automatic logic in_win(
		input logic [ql_map_pkg::CPU_ADDR_W-1:0] a,
		input logic [ql_map_pkg::CPU_ADDR_W-1:0] base,
		input logic [ql_map_pkg::CPU_ADDR_W-1:0] size
	);
		return (a - base) < size;
	endfunction

	// ------------------------------------------------------------------------
	// region
	// ------------------------------------------------------------------------
	always_comb begin
		region = ql_map_pkg::REG_NONE;
		// no bus activity, nothing selected
		if (bus.act) begin
			if (in_win(bus.addr, ql_map_pkg::ROM_BASE, ql_map_pkg::ROM_SIZE))
				region = ql_map_pkg::REG_ROM;
			else if (in_win(bus.addr, ql_map_pkg::IO_BASE, ql_map_pkg::IO_SIZE))
				region = ql_map_pkg::REG_IO;
			else if (in_win(bus.addr, ql_map_pkg::BRAM_BASE, ql_map_pkg::BRAM_SIZE))
				region = ql_map_pkg::REG_BRAM;
			// expansion only when enabled
			else if (ram_640k && in_win(bus.addr, ql_map_pkg::XRAM_BASE, ql_map_pkg::XRAM_SIZE))
				region = ql_map_pkg::REG_XRAM;
		end
	end

	assign is_io    = (region == ql_map_pkg::REG_IO);
	assign cpu_slot = !video_cycle;

	// ------------------------------------------------------------------------
	// chip selects
	// ------------------------------------------------------------------------

	// display controller, single write-only register at $18063
	assign zx8301_cs = cpu_slot && is_io && bus.addr[6] && bus.addr[5] && bus.addr[1]
		&& bus.wr && bus.lds;

	// peripheral controller, lower half of each I/O block
	assign zx8302_sel = cpu_slot && is_io && !bus.addr[6];

	// mouse sits in page $1bfxx, independent of slot
	assign qimi_sel = is_io && (bus.addr[13:8] == ql_map_pkg::QIMI_PAGE);

	// register index from bits 5 and 1
	assign zx8302_addr = {bus.addr[5], bus.addr[1]};
	assign qimi_addr   = {bus.addr[5], bus.addr[1]};

endmodule

// ==== design/ql_bus_fabric.sv ====
/*
 * QL bus fabric top level
 * ties CPU bus, SDRAM slot arbiter, address decoder, data return and reset
 */
`timescale 1ns/100ps

module ql_bus_fabric #(
	parameter int reset_cnt_w = 12
) (
	input  logic                                clk2,
	input  logic                                rst,
	input  logic                                reset_button,
	input  logic                                reset_menu,
	input  logic                                ram_640k,
	// cpu bus
	input  logic [ql_map_pkg::CPU_ADDR_W-1:0]   cpu_addr,
	input  ql_bus_pkg::bus_state_t              cpu_state,
	input  logic                                cpu_write_n,
	input  logic                                cpu_uds,
	input  logic                                cpu_lds,
	input  logic [ql_bus_pkg::DATA_W-1:0]       cpu_wdata,
	output logic [ql_bus_pkg::DATA_W-1:0]       cpu_rdata,
	output logic                                cpu_enable,
	// download channel
	input  logic                                dl_active,
	input  logic [ql_bus_pkg::DL_IDX_W-1:0]     dl_index,
	input  logic [ql_bus_pkg::MEM_ADDR_W-1:0]   dl_addr,
	input  logic [ql_bus_pkg::DATA_W-1:0]       dl_data,
	input  logic                                dl_write,
	// video fetcher
	input  logic [ql_bus_pkg::VID_ADDR_W-1:0]   video_addr,
	input  logic                                video_rd,
	output logic                                video_cycle,
	// sdram port
	output logic [ql_bus_pkg::MEM_ADDR_W-1:0]   mem_addr,
	output logic                                mem_wr,
	output logic                                mem_oe,
	output logic                                mem_uds,
	output logic                                mem_lds,
	output logic [ql_bus_pkg::DATA_W-1:0]       mem_wdata,
	input  logic [ql_bus_pkg::DATA_W-1:0]       mem_rdata,
	// on-board i/o
	output logic                                zx8301_cs,
	output logic                                zx8302_sel,
	output logic [1:0]                          zx8302_addr,
	input  logic [ql_bus_pkg::DATA_W-1:0]       zx8302_rdata,
	output logic                                qimi_sel,
	output logic [1:0]                          qimi_addr,
	input  logic [7:0]                          qimi_rdata,
	// status
	output ql_map_pkg::region_t                 region,
	output logic                                sys_reset
);

	cpu_bus_if u_bus ();

	// ------------------------------------------------------------------------
	// cpu bus bundle, source side
	// ------------------------------------------------------------------------
	assign u_bus.addr    = cpu_addr;
	assign u_bus.state   = cpu_state;
	assign u_bus.write_n = cpu_write_n;
	assign u_bus.uds     = cpu_uds;
	assign u_bus.lds     = cpu_lds;
	assign u_bus.wdata   = cpu_wdata;

	ql_addr_decode u_decode (
		.bus         (u_bus),
		.video_cycle (video_cycle),
		.ram_640k    (ram_640k),
		.region      (region),
		.zx8301_cs   (zx8301_cs),
		.zx8302_sel  (zx8302_sel),
		.zx8302_addr (zx8302_addr),
		.qimi_sel    (qimi_sel),
		.qimi_addr   (qimi_addr)
	);

	// video and system share sdram on alternate clk2 cycles
	ql_mem_arbiter u_arbiter (
		.clk2        (clk2),
		.rst         (rst),
		.bus         (u_bus),
		.region      (region),
		.dl_active   (dl_active),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.dl_write    (dl_write),
		.video_addr  (video_addr),
		.video_rd    (video_rd),
		.sys_reset   (sys_reset),
		.video_cycle (video_cycle),
		.cpu_enable  (cpu_enable),
		.mem_addr    (mem_addr),
		.mem_wr      (mem_wr),
		.mem_oe      (mem_oe),
		.mem_uds     (mem_uds),
		.mem_lds     (mem_lds),
		.mem_wdata   (mem_wdata)
	);

	ql_data_return u_return (
		.bus          (u_bus),
		.region       (region),
		.qimi_sel     (qimi_sel),
		.mem_rdata    (mem_rdata),
		.zx8302_rdata (zx8302_rdata),
		.qimi_rdata   (qimi_rdata),
		.cpu_rdata    (cpu_rdata)
	);

	ql_reset_gen #(
		.reset_cnt_w (reset_cnt_w)
	) u_reset (
		.clk2         (clk2),
		.rst          (rst),
		.reset_button (reset_button),
		.reset_menu   (reset_menu),
		.dl_active    (dl_active),
		.dl_index     (dl_index),
		.sys_reset    (sys_reset)
	);

endmodule

// ==== design/ql_bus_pkg.sv ====
/*
 * QL bus definitions
 * CPU bus state codes, data and SDRAM address widths, download indices
 */

package ql_bus_pkg;

	// bus data width
	localparam int DATA_W     = 16;
	// SDRAM word address
	localparam int MEM_ADDR_W = 25;
	// video fetcher word address
	localparam int VID_ADDR_W = 19;
	// download channel index
	localparam int DL_IDX_W   = 5;

	// CPU bus state as the 68000 core reports it
	typedef enum logic [1:0] {
		BUS_FETCH = 2'b00,
		BUS_IDLE  = 2'b01,
		BUS_READ  = 2'b10,
		BUS_WRITE = 2'b11
	} bus_state_t;

	// ------------------------------------------------------------------------
	// download indices that carry a ROM image
	// ------------------------------------------------------------------------
	localparam logic [DL_IDX_W-1:0] DL_ROM_A = DL_IDX_W'(0);
	localparam logic [DL_IDX_W-1:0] DL_ROM_B = DL_IDX_W'(3);

endpackage

// ==== design/ql_data_return.sv ====
/*
 * QL read data return
 * selects memory, I/O or open-bus data for the CPU
 */
`timescale 1ns/100ps

module ql_data_return (
	cpu_bus_if.consumer                     bus,
	input  ql_map_pkg::region_t             region,
	input  logic                            qimi_sel,
	input  logic [ql_bus_pkg::DATA_W-1:0]   mem_rdata,
	input  logic [ql_bus_pkg::DATA_W-1:0]   zx8302_rdata,
	input  logic [7:0]                      qimi_rdata,
	output logic [ql_bus_pkg::DATA_W-1:0]   cpu_rdata
);

	logic [ql_bus_pkg::DATA_W-1:0] io_rdata;

	// i/o sources, mouse byte appears on both lanes
	always_comb begin
		if (qimi_sel)
			io_rdata = {2{qimi_rdata}};
		else if (!bus.addr[6])
			io_rdata = zx8302_rdata;
		else
			io_rdata = '0;
	end

	// ------------------------------------------------------------------------
	// return mux
	// ------------------------------------------------------------------------
	always_comb begin
		case (region)
			ql_map_pkg::REG_ROM,
			ql_map_pkg::REG_BRAM,
			ql_map_pkg::REG_XRAM: cpu_rdata = mem_rdata;
			ql_map_pkg::REG_IO:   cpu_rdata = io_rdata;
			// open bus
			default:              cpu_rdata = '1;
		endcase
	end

endmodule

// ==== design/ql_map_pkg.sv ====
/*
 * QL memory map
 * region codes and the CPU address windows of ROM, RAM and on-board I/O
 */

package ql_map_pkg;

	// width of the decoded CPU byte address (1 MiB space)
	localparam int CPU_ADDR_W = 20;

	// decoded target of a CPU access
	typedef enum logic [2:0] {
		REG_ROM  = 3'd0,
		REG_BRAM = 3'd1,
		REG_XRAM = 3'd2,
		REG_IO   = 3'd3,
		REG_NONE = 3'd4
	} region_t;

	// ------------------------------------------------------------------------
	// address windows, base and size in bytes
	// ------------------------------------------------------------------------

	// 64k system ROM
	localparam logic [CPU_ADDR_W-1:0] ROM_BASE  = 20'h00000;
	localparam logic [CPU_ADDR_W-1:0] ROM_SIZE  = 20'h10000;
	// internal I/O, $18000 up to $1bfff
	localparam logic [CPU_ADDR_W-1:0] IO_BASE   = 20'h18000;
	localparam logic [CPU_ADDR_W-1:0] IO_SIZE   = 20'h04000;
	// 128k base RAM
	localparam logic [CPU_ADDR_W-1:0] BRAM_BASE = 20'h20000;
	localparam logic [CPU_ADDR_W-1:0] BRAM_SIZE = 20'h20000;
	// 512k expansion RAM, only with the 640k option
	localparam logic [CPU_ADDR_W-1:0] XRAM_BASE = 20'h40000;
	localparam logic [CPU_ADDR_W-1:0] XRAM_SIZE = 20'h80000;

	// mouse page inside the I/O window, address bits 13..8
	localparam logic [5:0] QIMI_PAGE = 6'b111111;

endpackage

// ==== design/ql_mem_arbiter.sv ====
/*
 * QL SDRAM slot arbiter
 * alternates video and system slots on the SDRAM port, gates the CPU clock enable
 */
`timescale 1ns/100ps

module ql_mem_arbiter (
	input  logic                                clk2,
	input  logic                                rst,
	cpu_bus_if.consumer                         bus,
	input  ql_map_pkg::region_t                 region,
	input  logic                                dl_active,
	input  logic [ql_bus_pkg::MEM_ADDR_W-1:0]   dl_addr,
	input  logic [ql_bus_pkg::DATA_W-1:0]       dl_data,
	input  logic                                dl_write,
	input  logic [ql_bus_pkg::VID_ADDR_W-1:0]   video_addr,
	input  logic                                video_rd,
	input  logic                                sys_reset,
	output logic                                video_cycle,
	output logic                                cpu_enable,
	output logic [ql_bus_pkg::MEM_ADDR_W-1:0]   mem_addr,
	output logic                                mem_wr,
	output logic                                mem_oe,
	output logic                                mem_uds,
	output logic                                mem_lds,
	output logic [ql_bus_pkg::DATA_W-1:0]       mem_wdata
);

	typedef enum logic {
		SLOT_CPU   = 1'b0,
		SLOT_VIDEO = 1'b1
	} slot_t;

	slot_t slot;

	logic                              cpu_ram;
	logic                              cpu_mem;
	logic [ql_bus_pkg::MEM_ADDR_W-1:0] sys_addr;
	logic                              sys_wr;
	logic                              sys_oe;
	logic                              sys_uds;
	logic                              sys_lds;
	logic [ql_bus_pkg::DATA_W-1:0]     sys_wdata;

	// ------------------------------------------------------------------------
	// slot flag, cpu slot during reset so the first slot after is video
	// ------------------------------------------------------------------------
	always_ff @(posedge clk2) begin
		if (rst)
			slot <= SLOT_CPU;
		else
			slot <= (slot == SLOT_VIDEO) ? SLOT_CPU : SLOT_VIDEO;
	end

	assign video_cycle = (slot == SLOT_VIDEO);

	// ------------------------------------------------------------------------
	// system side: download channel or CPU
	// ------------------------------------------------------------------------
	assign cpu_ram = (region == ql_map_pkg::REG_BRAM) || (region == ql_map_pkg::REG_XRAM);
	// anything backed by sdram
	assign cpu_mem = cpu_ram || (region == ql_map_pkg::REG_ROM);

	// download owns the system slot, the CPU is stalled meanwhile
	assign sys_addr  = dl_active ? dl_addr
		: ql_bus_pkg::MEM_ADDR_W'(bus.addr[ql_map_pkg::CPU_ADDR_W-1:1]);
	assign sys_uds   = dl_active ? 1'b1 : bus.uds;
	assign sys_lds   = dl_active ? 1'b1 : bus.lds;
	assign sys_wdata = dl_active ? dl_data : bus.wdata;
	// rom is write protected from the CPU side
	assign sys_wr    = dl_active ? dl_write : (bus.wr && cpu_ram);
	assign sys_oe    = dl_active ? 1'b0 : (bus.rd && cpu_mem);

	// ------------------------------------------------------------------------
	// sdram port mux
	// ------------------------------------------------------------------------
	// video slot reads only, full word
	assign mem_addr  = video_cycle ? ql_bus_pkg::MEM_ADDR_W'(video_addr) : sys_addr;
	assign mem_wr    = video_cycle ? 1'b0 : sys_wr;
	assign mem_oe    = video_cycle ? video_rd : sys_oe;
	assign mem_uds   = video_cycle ? 1'b1 : sys_uds;
	assign mem_lds   = video_cycle ? 1'b1 : sys_lds;
	assign mem_wdata = sys_wdata;

	// cpu runs in its own slot unless a download holds it
	// an idle bus cycle needs no slot
	assign cpu_enable = !sys_reset
		&& ((!video_cycle && !dl_active) || (bus.state == ql_bus_pkg::BUS_IDLE));

endmodule

// ==== design/ql_reset_gen.sv ====
/*
 * QL reset stretcher
 * holds system reset for a fixed count after any reset cause
 */
`timescale 1ns/100ps

module ql_reset_gen #(
	parameter int reset_cnt_w = 12
) (
	input  logic                              clk2,
	input  logic                              rst,
	input  logic                              reset_button,
	input  logic                              reset_menu,
	input  logic                              dl_active,
	input  logic [ql_bus_pkg::DL_IDX_W-1:0]   dl_index,
	output logic                              sys_reset
);

	logic [reset_cnt_w-1:0] cnt;
	logic                   rom_load;
	logic                   reload;

	// a fresh ROM image restarts the machine
	assign rom_load = dl_active
		&& ((dl_index == ql_bus_pkg::DL_ROM_A) || (dl_index == ql_bus_pkg::DL_ROM_B));

	assign reload = rst || reset_button || reset_menu || rom_load;

	// reload while any cause is present, then count down to zero
	always_ff @(posedge clk2) begin
		if (reload)
			cnt <= '1;
		else if (cnt != '0)
			cnt <= cnt - reset_cnt_w'(1);
	end

	assign sys_reset = (cnt != '0);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the QL bus fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f src.f --top-module tb_ql_bus_fabric -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== src.f ====
design/ql_map_pkg.sv
design/ql_bus_pkg.sv
design/cpu_bus_if.sv
design/ql_addr_decode.sv
design/ql_mem_arbiter.sv
design/ql_data_return.sv
design/ql_reset_gen.sv
design/ql_bus_fabric.sv
tests/ql_bus_asserts.sv
tests/tb_ql_bus_fabric.sv

// ==== tests/ql_bus_asserts.sv ====
/*
 * SDRAM slot rule checks
 * bound into the slot arbiter
 */
`timescale 1ns/100ps

module ql_bus_asserts (
	input logic clk2,
	input logic rst,
	input logic video_cycle,
	input logic mem_wr,
	input logic cpu_enable,
	input logic sys_reset
);

	// video slot is read only
	a_no_video_write: assert property (@(posedge clk2) disable iff (rst)
		video_cycle |-> !mem_wr)
		else $error("SDRAM write issued in a video slot");

	// slots strictly alternate once out of reset
	a_slot_toggle: assert property (@(posedge clk2) disable iff (rst)
		!$past(rst) |-> (video_cycle != $past(video_cycle)))
		else $error("slot flag did not toggle");

	// cpu held while the system is in reset
	a_enable_in_reset: assert property (@(posedge clk2)
		sys_reset |-> !cpu_enable)
		else $error("cpu_enable high during system reset");

endmodule

bind ql_mem_arbiter ql_bus_asserts u_asserts (
	.clk2        (clk2),
	.rst         (rst),
	.video_cycle (video_cycle),
	.mem_wr      (mem_wr),
	.cpu_enable  (cpu_enable),
	.sys_reset   (sys_reset)
);

// ==== tests/ql_bus_stim.txt ====
# addr state write_n uds lds wdata ram_640k dl_active dl_index dl_addr dl_data dl_write, all hex
# expected: region (0 rom 1 bram 2 xram 3 io 4 none) zx8301_cs zx8302_sel qimi_sel, cpu slot
00100 2 1 1 1 0000 0 0 0 0000000 0000 0 0 0 0 0
0fffe 0 1 1 1 0000 0 0 0 0000000 0000 0 0 0 0 0
00200 3 0 1 1 1234 0 0 0 0000000 0000 0 0 0 0 0
18000 2 1 1 1 0000 0 0 0 0000000 0000 0 3 0 1 0
18063 3 0 0 1 00a5 0 0 0 0000000 0000 0 3 1 0 0
18063 3 0 1 0 a500 0 0 0 0000000 0000 0 3 0 0 0
18063 2 1 1 1 0000 0 0 0 0000000 0000 0 3 0 0 0
18022 2 1 1 1 0000 0 0 0 0000000 0000 0 3 0 1 0
1bf00 2 1 1 1 0000 0 0 0 0000000 0000 0 3 0 1 1
1bf62 2 1 1 1 0000 0 0 0 0000000 0000 0 3 0 0 1
1c000 2 1 1 1 0000 0 0 0 0000000 0000 0 4 0 0 0
20000 3 0 1 1 beef 0 0 0 0000000 0000 0 1 0 0 0
3fffe 2 1 1 1 0000 0 0 0 0000000 0000 0 1 0 0 0
40000 2 1 1 1 0000 0 0 0 0000000 0000 0 4 0 0 0
40000 2 1 1 1 0000 1 0 0 0000000 0000 0 2 0 0 0
bfffe 3 0 1 1 cafe 1 0 0 0000000 0000 0 2 0 0 0
c0000 2 1 1 1 0000 1 0 0 0000000 0000 0 4 0 0 0
20010 1 1 1 1 0000 0 0 0 0000000 0000 0 4 0 0 0
20010 3 1 1 1 1111 0 0 0 0000000 0000 0 4 0 0 0
20020 2 1 1 1 0000 0 1 1 0123456 5a5a 1 1 0 0 0
18000 1 1 1 1 0000 0 1 2 1000000 0f0f 0 4 0 0 0
00000 0 1 1 1 0000 0 0 0 0000000 0000 0 0 0 0 0

// ==== tests/tb_ql_bus_fabric.sv ====
/*
 * QL bus fabric testbench
 * stimulus vectors from file, reference model for the SDRAM port, return data and reset
 */
`timescale 1ns/100ps

module tb_ql_bus_fabric;

	// short stretch counter keeps the reset checks quick
	localparam int RESET_CNT_W = 4;
	localparam int STRETCH     = (1 << RESET_CNT_W) - 1;

	logic                   clk2;
	logic                   rst;
	logic                   reset_button;
	logic                   reset_menu;
	logic                   ram_640k;
	logic [19:0]            cpu_addr;
	ql_bus_pkg::bus_state_t cpu_state;
	logic                   cpu_write_n;
	logic                   cpu_uds;
	logic                   cpu_lds;
	logic [15:0]            cpu_wdata;
	logic [15:0]            cpu_rdata;
	logic                   cpu_enable;
	logic                   dl_active;
	logic [4:0]             dl_index;
	logic [24:0]            dl_addr;
	logic [15:0]            dl_data;
	logic                   dl_write;
	logic [18:0]            video_addr;
	logic                   video_rd;
	logic                   video_cycle;
	logic [24:0]            mem_addr;
	logic                   mem_wr;
	logic                   mem_oe;
	logic                   mem_uds;
	logic                   mem_lds;
	logic [15:0]            mem_wdata;
	logic [15:0]            mem_rdata;
	logic                   zx8301_cs;
	logic                   zx8302_sel;
	logic [1:0]             zx8302_addr;
	logic [15:0]            zx8302_rdata;
	logic                   qimi_sel;
	logic [1:0]             qimi_addr;
	logic [7:0]             qimi_rdata;
	ql_map_pkg::region_t    region;
	logic                   sys_reset;

	// current vector, as read from the stim file
	logic [19:0] v_addr;
	logic [1:0]  v_state;
	logic        v_wn;
	logic        v_uds;
	logic        v_lds;
	logic [15:0] v_wdata;
	logic        v_640;
	logic        v_dla;
	logic [4:0]  v_dli;
	logic [24:0] v_dladdr;
	logic [15:0] v_dldata;
	logic        v_dlw;
	logic [2:0]  v_region;
	logic        v_z01;
	logic        v_z02;
	logic        v_qimi;

	logic [31:0] lfsr;
	logic        exp_vc;
	logic        slot_check_on = 1'b0;
	int          err_cnt = 0;
	int          timeout_cnt = 0;
	int          nvec = 0;

	// port names match one to one
	ql_bus_fabric #(
		.reset_cnt_w (RESET_CNT_W)
	) u_dut (.*);

	initial begin
		clk2 = 1'b0;
		forever #50 clk2 = ~clk2;
	end

	// expected slot, video first after reset
	always @(posedge clk2) begin
		exp_vc <= rst ? 1'b0 : !exp_vc;
	end

	always @(negedge clk2) begin
		if (slot_check_on)
			compare_field("video_cycle", 32'(video_cycle), 32'(exp_vc));
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------

	// right-shift galois form, taps 32 22 2 1
	function automatic logic [31:0] step_lfsr(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// one lfsr step per bit taken
	task automatic rand_bits(input int n, output logic [31:0] val);
		int i;
		val = '0;
		for (i = 0; i < n; i++) begin
			lfsr = step_lfsr(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic compare_field(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			err_cnt++;
			$display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// memory, i/o and video side inputs
	task automatic drive_random();
		logic [31:0] r;
		rand_bits(16, r);
		mem_rdata <= r[15:0];
		rand_bits(16, r);
		zx8302_rdata <= r[15:0];
		rand_bits(8, r);
		qimi_rdata <= r[7:0];
		rand_bits(19, r);
		video_addr <= r[18:0];
		rand_bits(1, r);
		video_rd <= r[0];
	endtask

	// ------------------------------------------------------------------------
	// reference model and checks for one cycle
	// ------------------------------------------------------------------------
	task automatic check_outputs();
		logic        rd;
		logic        wr;
		logic        ram;
		logic        mem;
		logic [24:0] e_addr;
		logic        e_wr;
		logic        e_oe;
		logic        e_uds;
		logic        e_lds;
		logic        e_en;
		logic [15:0] e_wdata;
		logic [15:0] e_rdata;
		rd  = (cpu_state == ql_bus_pkg::BUS_FETCH) || (cpu_state == ql_bus_pkg::BUS_READ);
		wr  = (cpu_state == ql_bus_pkg::BUS_WRITE) && !cpu_write_n;
		ram = (v_region == 3'd1) || (v_region == 3'd2);
		mem = ram || (v_region == 3'd0);
		// system side, download owns it
		if (dl_active) begin
			e_addr  = dl_addr;
			e_wr    = dl_write;
			e_oe    = 1'b0;
			e_uds   = 1'b1;
			e_lds   = 1'b1;
			e_wdata = dl_data;
		end else begin
			e_addr  = {6'b0, cpu_addr[19:1]};
			e_wr    = wr && ram;
			e_oe    = rd && mem;
			e_uds   = cpu_uds;
			e_lds   = cpu_lds;
			e_wdata = cpu_wdata;
		end
		// video slot overrides all but write data
		if (exp_vc) begin
			e_addr = {6'b0, video_addr};
			e_wr   = 1'b0;
			e_oe   = video_rd;
			e_uds  = 1'b1;
			e_lds  = 1'b1;
		end
		e_en = (!exp_vc && !dl_active) || (cpu_state == ql_bus_pkg::BUS_IDLE);
		case (v_region)
			3'd0, 3'd1, 3'd2: e_rdata = mem_rdata;
			3'd3: begin
				if (v_qimi)
					e_rdata = {2{qimi_rdata}};
				else if (!cpu_addr[6])
					e_rdata = zx8302_rdata;
				else
					e_rdata = 16'h0000;
			end
			default: e_rdata = 16'hffff;
		endcase
		compare_field("region", 32'(region), 32'(v_region));
		compare_field("zx8301_cs", 32'(zx8301_cs), 32'(v_z01 && !exp_vc));
		compare_field("zx8302_sel", 32'(zx8302_sel), 32'(v_z02 && !exp_vc));
		compare_field("qimi_sel", 32'(qimi_sel), 32'(v_qimi));
		compare_field("zx8302_addr", 32'(zx8302_addr), 32'({cpu_addr[5], cpu_addr[1]}));
		compare_field("qimi_addr", 32'(qimi_addr), 32'({cpu_addr[5], cpu_addr[1]}));
		compare_field("mem_addr", 32'(mem_addr), 32'(e_addr));
		compare_field("mem_wr", 32'(mem_wr), 32'(e_wr));
		compare_field("mem_oe", 32'(mem_oe), 32'(e_oe));
		compare_field("mem_uds", 32'(mem_uds), 32'(e_uds));
		compare_field("mem_lds", 32'(mem_lds), 32'(e_lds));
		compare_field("mem_wdata", 32'(mem_wdata), 32'(e_wdata));
		compare_field("cpu_enable", 32'(cpu_enable), 32'(e_en));
		compare_field("cpu_rdata", 32'(cpu_rdata), 32'(e_rdata));
		compare_field("sys_reset", 32'(sys_reset), 32'd0);
	endtask

	// hold a vector for one video and one cpu slot
	task automatic apply_vector();
		@(posedge clk2);
		cpu_addr    <= v_addr;
		cpu_state   <= ql_bus_pkg::bus_state_t'(v_state);
		cpu_write_n <= v_wn;
		cpu_uds     <= v_uds;
		cpu_lds     <= v_lds;
		cpu_wdata   <= v_wdata;
		ram_640k    <= v_640;
		dl_active   <= v_dla;
		dl_index    <= v_dli;
		dl_addr     <= v_dladdr;
		dl_data     <= v_dldata;
		dl_write    <= v_dlw;
		drive_random();
		@(negedge clk2);
		check_outputs();
		@(posedge clk2);
		drive_random();
		@(negedge clk2);
		check_outputs();
	endtask

	task automatic wait_reset_done(input int limit);
		int n;
		n = 0;
		while (sys_reset !== 1'b0 && n < limit) begin
			@(negedge clk2);
			n++;
		end
		if (sys_reset !== 1'b0) begin
			timeout_cnt++;
			$display("timed out waiting for system reset to clear after power-on");
		end
	endtask

	// ------------------------------------------------------------------------
	// reset causes
	// ------------------------------------------------------------------------
	// kind 0 button, 1 menu, 2 rom download index 0, 3 rom download index 3
	task automatic pulse_cause(input int kind, input string name);
		int   high;
		int   n;
		logic done;
		high = 0;
		n    = 0;
		done = 1'b0;
		@(posedge clk2);
		case (kind)
			0: reset_button <= 1'b1;
			1: reset_menu <= 1'b1;
			default: begin
				dl_active <= 1'b1;
				dl_index  <= (kind == 2) ? 5'd0 : 5'd3;
			end
		endcase
		// registered, not yet visible
		@(negedge clk2);
		compare_field({name, " sys_reset early"}, 32'(sys_reset), 32'd0);
		@(posedge clk2);
		reset_button <= 1'b0;
		reset_menu   <= 1'b0;
		dl_active    <= 1'b0;
		while (!done && n < 4 * STRETCH) begin
			@(negedge clk2);
			if (sys_reset) begin
				high++;
				compare_field({name, " cpu_enable in reset"}, 32'(cpu_enable), 32'd0);
			end else begin
				done = 1'b1;
			end
			n++;
		end
		if (!done) begin
			timeout_cnt++;
			$display("timed out waiting for system reset to clear after %s", name);
		end else begin
			compare_field({name, " stretch cycles"}, 32'(high), 32'(STRETCH));
			// idle bus runs again
			compare_field({name, " cpu_enable after"}, 32'(cpu_enable), 32'd1);
		end
	endtask

	// non-rom download must leave the machine running
	task automatic check_plain_download();
		int i;
		@(posedge clk2);
		dl_active <= 1'b1;
		dl_index  <= 5'd1;
		for (i = 0; i < 4; i++) begin
			@(negedge clk2);
			compare_field("index 1 sys_reset", 32'(sys_reset), 32'd0);
		end
		@(posedge clk2);
		dl_active <= 1'b0;
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		int    fd;
		int    rc;
		string line;
		lfsr         = 32'hc96dc06e;
		rst          = 1'b1;
		reset_button = 1'b0;
		reset_menu   = 1'b0;
		ram_640k     = 1'b0;
		cpu_addr     = '0;
		cpu_state    = ql_bus_pkg::BUS_IDLE;
		cpu_write_n  = 1'b1;
		cpu_uds      = 1'b0;
		cpu_lds      = 1'b0;
		cpu_wdata    = '0;
		dl_active    = 1'b0;
		dl_index     = '0;
		dl_addr      = '0;
		dl_data      = '0;
		dl_write     = 1'b0;
		video_addr   = '0;
		video_rd     = 1'b0;
		mem_rdata    = '0;
		zx8302_rdata = '0;
		qimi_rdata   = '0;

		repeat (2) @(posedge clk2);
		rst <= 1'b0;
		slot_check_on = 1'b1;
		wait_reset_done(8 * STRETCH);

		fd = $fopen("tests/ql_bus_stim.txt", "r");
		if (fd == 0) begin
			err_cnt++;
			$display("could not open stimulus file tests/ql_bus_stim.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				// skip column notes and blank lines
				if (line.len() > 1 && line[0] != "#") begin
					rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						v_addr, v_state, v_wn, v_uds, v_lds, v_wdata, v_640, v_dla,
						v_dli, v_dladdr, v_dldata, v_dlw, v_region, v_z01, v_z02, v_qimi);
					if (rc != 16) begin
						err_cnt++;
						$display("malformed stimulus line: %s", line);
					end else begin
						apply_vector();
						nvec++;
					end
				end
			end
			$fclose(fd);
			if (nvec == 0) begin
				err_cnt++;
				$display("no stimulus vectors found in tests/ql_bus_stim.txt");
			end
		end

		// quiet bus for the reset checks
		@(posedge clk2);
		cpu_state <= ql_bus_pkg::BUS_IDLE;
		dl_active <= 1'b0;
		pulse_cause(0, "reset_button");
		pulse_cause(1, "reset_menu");
		pulse_cause(2, "download index 0");
		pulse_cause(3, "download index 3");
		check_plain_download();

		$display("vectors %0d, errors %0d, timeouts %0d", nvec, err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
